// ==== all.f ====
+incdir+rtl
rtl/fw_pkg.sv
rtl/fw_stage_table.sv
rtl/fw_operand_select.sv
rtl/fw_operand_latch.sv
rtl/forward_unit.sv
dv/forward_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module forward_unit_tb -f all.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vforward_unit_tb > sim.log 2>&1
cat sim.log

! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== dv/forward_unit_tb.sv ====
`timescale 1ns/100ps

`include "fw_defines.svh"

module forward_unit_tb import fw_pkg::*; ();

    localparam int HALF_PERIOD     = 2;
    localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int SLACK_CYCLES    = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + SLACK_CYCLES;
    localparam int NUM_OPERANDS    = 5;  // ra_ep, rb_ep, rc_ep, ra_op, rb_op
    localparam int RANDOM_SEED     = 32'h330d_faed;

    logic           clock = 1'b0;
    logic           rst_n;
    reg_addr_t      src_addr [0:NUM_OPERANDS-1];
    reg_value_t     rf_value [0:NUM_OPERANDS-1];
    reg_value_t     fw_out   [0:NUM_OPERANDS-1];
    stage_records_t ep_stage_records;
    stage_records_t op_stage_records;

    // field view of the records where pipe 0 is even and pipe 1 is odd
    logic           stage_we   [0:1][1:`FW_NUM_STAGES];
    reg_addr_t      stage_addr [0:1][1:`FW_NUM_STAGES];
    unit_latency_t  stage_lat  [0:1][1:`FW_NUM_STAGES];
    reg_value_t     stage_val  [0:1][1:`FW_NUM_STAGES];

    reg_value_t     model_out [0:NUM_OPERANDS-1];
    logic           check_en = 1'b0;
    int             mismatch_count [0:NUM_OPERANDS-1] = '{default: 0};
    string          test_name = "init";
    string          issued_test = "reset";
    string          checked_test = "reset";
    int unsigned    seed_ret;

    always #(HALF_PERIOD) clock = ~clock;

    forward_unit u_dut (
        .clock            (clock),
        .rst_n            (rst_n),
        .ra_address_ep    (src_addr[0]),
        .rb_address_ep    (src_addr[1]),
        .rc_address_ep    (src_addr[2]),
        .ra_address_op    (src_addr[3]),
        .rb_address_op    (src_addr[4]),
        .ra_value_ep      (rf_value[0]),
        .rb_value_ep      (rf_value[1]),
        .rc_value_ep      (rf_value[2]),
        .ra_value_op      (rf_value[3]),
        .rb_value_op      (rf_value[4]),
        .ep_stage_records (ep_stage_records),
        .op_stage_records (op_stage_records),
        .ra_value_fw_ep   (fw_out[0]),
        .rb_value_fw_ep   (fw_out[1]),
        .rc_value_fw_ep   (fw_out[2]),
        .ra_value_fw_op   (fw_out[3]),
        .rb_value_fw_op   (fw_out[4])
    );

    function automatic string operand_name(input int idx);
        case (idx)
            0:       return "ra_ep";
            1:       return "rb_ep";
            2:       return "rc_ep";
            3:       return "ra_op";
            default: return "rb_op";
        endcase
    endfunction

    // readiness and priority straight from the forwarding rules
    function automatic reg_value_t expected_operand(input reg_addr_t addr,
                                                    input reg_value_t rf,
                                                    input int own);
        reg_value_t result;
        bit         hit;
        int         pipe;
        result = rf;
        hit    = 1'b0;
        for (int depth = 1; depth <= `FW_NUM_STAGES; depth++) begin
            for (int k = 0; k < 2; k++) begin
                pipe = (k == 0) ? own : 1 - own;  // own pipe is looked at first
                if (!hit && stage_we[pipe][depth] && (stage_lat[pipe][depth] != '0)
                    && (int'(stage_lat[pipe][depth]) <= depth)
                    && (stage_addr[pipe][depth] == addr)) begin
                    result = stage_val[pipe][depth];
                    hit    = 1'b1;
                end
            end
        end
        return result;
    endfunction

    // expected operand registers trail the inputs by one cycle like the DUT
    always @(posedge clock) begin
        check_en <= 1'b1;
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            if (!rst_n) begin
                model_out[i] <= '0;
            end else begin
                model_out[i] <= expected_operand(src_addr[i], rf_value[i], (i < 3) ? 0 : 1);
            end
        end
    end

    // the name follows its inputs through the operand registers to the check
    always @(negedge clock) begin
        issued_test  <= test_name;
        checked_test <= issued_test;
    end

    for (genvar i = 0; i < NUM_OPERANDS; i++) begin : g_check
        a_operand_value: assert property (
            @(posedge clock) check_en |-> (fw_out[i] == model_out[i])
        ) else begin
            mismatch_count[i]++;
            $display("Mismatch test %s operand %s expected %h actual %h", checked_test,
                     operand_name(i), $sampled(model_out[i]), $sampled(fw_out[i]));
        end
    end

    function automatic reg_value_t random_value();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic set_stage(input int pipe, input int depth, input int we, input int addr,
                             input int lat, input reg_value_t value, input int id);
        stage_record_t rec;
        stage_we[pipe][depth]   = (we != 0);
        stage_addr[pipe][depth] = reg_addr_t'(addr);
        stage_lat[pipe][depth]  = unit_latency_t'(lat);
        stage_val[pipe][depth]  = value;
        rec = '0;
        rec[`FW_ID_MSB:`FW_ID_LSB]       = id[`FW_UNIT_ID_W-1:0];
        rec[`FW_VALUE_MSB:`FW_VALUE_LSB] = value;
        rec[`FW_WE_BIT]                  = stage_we[pipe][depth];
        rec[`FW_ADDR_MSB:`FW_ADDR_LSB]   = stage_addr[pipe][depth];
        rec[`FW_LAT_MSB:`FW_LAT_LSB]     = stage_lat[pipe][depth];
        if (pipe == 0) begin
            ep_stage_records[depth] = rec;
        end else begin
            op_stage_records[depth] = rec;
        end
    endtask

    task automatic clear_stages();
        for (int p = 0; p < 2; p++) begin
            for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
                set_stage(p, d, 0, 0, 0, '0, 0);
            end
        end
    endtask

    task automatic point_sources(input int addr);
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            src_addr[i] = reg_addr_t'(addr);
            rf_value[i] = random_value();
        end
    endtask

    task automatic random_sources(input int max_addr);
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            src_addr[i] = reg_addr_t'($urandom_range(max_addr, 0));
            rf_value[i] = random_value();
        end
    endtask

    // write enable is high three times in four and then carries only legal latencies
    task automatic randomize_stages();
        int we;
        for (int p = 0; p < 2; p++) begin
            for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
                we = ($urandom_range(3, 0) != 0) ? 1 : 0;
                if (we != 0) begin
                    set_stage(p, d, 1, $urandom_range(7, 0), $urandom_range(8, 1),
                              random_value(), $urandom);
                end else begin
                    set_stage(p, d, 0, $urandom_range(7, 0), $urandom_range(15, 0),
                              random_value(), $urandom);
                end
            end
        end
    endtask

    initial begin
        int total;
        seed_ret = $urandom(RANDOM_SEED);
        rst_n = 1'b0;
        clear_stages();
        point_sources(3);
        set_stage(0, 1, 1, 3, 1, random_value(), 1);  // would forward if not in reset

        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clock);
        #0.5;
        rst_n = 1'b1;

        test_name = "register_file";
        for (int n = 0; n < 4; n++) begin
            clear_stages();
            random_sources(15);
            for (int p = 0; p < 2; p++) begin
                for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
                    set_stage(p, d, 1, 100 + 8 * p + d, 1, random_value(), d);
                end
            end
            next_cycle();
        end

        test_name = "not_ready";
        clear_stages();
        point_sources(5);
        set_stage(0, 3, 1, 5, 4, random_value(), 2);  // one stage short of its latency
        set_stage(1, 7, 1, 5, 8, random_value(), 3);
        set_stage(0, 1, 0, 5, 1, random_value(), 4);
        set_stage(1, 2, 0, 5, 0, random_value(), 5);
        set_stage(1, 8, 0, 5, 8, random_value(), 6);
        next_cycle();
        clear_stages();
        point_sources(5);
        for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
            set_stage(0, d, 0, 5, 1, random_value(), d);
            set_stage(1, d, 0, 5, 1, random_value(), d);
        end
        next_cycle();
        clear_stages();
        point_sources(5);
        set_stage(0, 4, 1, 5, 4, random_value(), 1);  // latency equal to depth is ready
        set_stage(1, 2, 1, 5, 3, random_value(), 2);
        next_cycle();

        test_name = "depth_order";
        for (int start = 1; start <= `FW_NUM_STAGES; start++) begin
            clear_stages();
            point_sources(9);
            for (int d = start; d <= `FW_NUM_STAGES; d++) begin
                set_stage(0, d, 1, 9, d, random_value(), d);
                if (d > start) begin
                    set_stage(1, d, 1, 9, 1, random_value(), d);
                end
            end
            next_cycle();
        end

        test_name = "write_back";
        clear_stages();
        point_sources(9);
        set_stage(0, 3, 1, 9, 5, random_value(), 1);
        set_stage(1, 6, 0, 9, 2, random_value(), 2);
        set_stage(1, 8, 1, 9, 8, random_value(), 3);
        next_cycle();
        clear_stages();
        point_sources(9);
        set_stage(0, 7, 1, 9, 8, random_value(), 1);
        set_stage(0, 8, 1, 9, 8, random_value(), 2);
        set_stage(1, 8, 1, 9, 3, random_value(), 3);
        next_cycle();

        test_name = "same_depth_tie";
        for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
            clear_stages();
            point_sources(20);
            set_stage(0, d, 1, 20, $urandom_range(d, 1), random_value(), d);
            set_stage(1, d, 1, 20, $urandom_range(d, 1), random_value(), d);
            if (d < `FW_NUM_STAGES) begin
                set_stage(0, d + 1, 1, 20, 1, random_value(), d);
                set_stage(1, d + 1, 1, 20, 1, random_value(), d);
            end
            next_cycle();
        end

        test_name = "random";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_sources(7);
            randomize_stages();
            next_cycle();
        end

        test_name = "drain";
        clear_stages();
        repeat (2) next_cycle();

        total = 0;
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            total += mismatch_count[i];
        end
        $display("mismatches ra_ep %0d rb_ep %0d rc_ep %0d ra_op %0d rb_op %0d total %0d",
                 mismatch_count[0], mismatch_count[1], mismatch_count[2],
                 mismatch_count[3], mismatch_count[4], total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== rtl/forward_unit.sv ====
`timescale 1ns/100ps

module forward_unit import fw_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  reg_addr_t      ra_address_ep,
    input  reg_addr_t      rb_address_ep,
    input  reg_addr_t      rc_address_ep,
    input  reg_addr_t      ra_address_op,
    input  reg_addr_t      rb_address_op,
    input  reg_value_t     ra_value_ep,
    input  reg_value_t     rb_value_ep,
    input  reg_value_t     rc_value_ep,
    input  reg_value_t     ra_value_op,
    input  reg_value_t     rb_value_op,
    input  stage_records_t ep_stage_records,
    input  stage_records_t op_stage_records,
    output reg_value_t     ra_value_fw_ep,
    output reg_value_t     rb_value_fw_ep,
    output reg_value_t     rc_value_fw_ep,
    output reg_value_t     ra_value_fw_op,
    output reg_value_t     rb_value_fw_op
);

    stage_values_t ep_values;
    stage_addrs_t  ep_addrs;
    stage_ready_t  ep_ready;
    stage_values_t op_values;
    stage_addrs_t  op_addrs;
    stage_ready_t  op_ready;

    reg_value_t ra_fw_ep;
    reg_value_t rb_fw_ep;
    reg_value_t rc_fw_ep;
    reg_value_t ra_fw_op;
    reg_value_t rb_fw_op;

    fw_stage_table u_stage_table (
        .clock            (clock),
        .rst_n            (rst_n),
        .ep_stage_records (ep_stage_records),
        .op_stage_records (op_stage_records),
        .ep_values        (ep_values),
        .ep_addrs         (ep_addrs),
        .ep_ready         (ep_ready),
        .op_values        (op_values),
        .op_addrs         (op_addrs),
        .op_ready         (op_ready)
    );

    // even pipe consumers
    fw_operand_select #(.OWN_PIPE_EVEN(1'b1)) u_sel_ra_ep (
        .src_addr (ra_address_ep), .rf_value (ra_value_ep),
        .ep_values(ep_values), .ep_addrs(ep_addrs), .ep_ready(ep_ready),
        .op_values(op_values), .op_addrs(op_addrs), .op_ready(op_ready),
        .fw_value (ra_fw_ep)
    );

    fw_operand_select #(.OWN_PIPE_EVEN(1'b1)) u_sel_rb_ep (
        .src_addr (rb_address_ep), .rf_value (rb_value_ep),
        .ep_values(ep_values), .ep_addrs(ep_addrs), .ep_ready(ep_ready),
        .op_values(op_values), .op_addrs(op_addrs), .op_ready(op_ready),
        .fw_value (rb_fw_ep)
    );

    fw_operand_select #(.OWN_PIPE_EVEN(1'b1)) u_sel_rc_ep (
        .src_addr (rc_address_ep), .rf_value (rc_value_ep),
        .ep_values(ep_values), .ep_addrs(ep_addrs), .ep_ready(ep_ready),
        .op_values(op_values), .op_addrs(op_addrs), .op_ready(op_ready),
        .fw_value (rc_fw_ep)
    );

    // odd pipe consumers
    fw_operand_select #(.OWN_PIPE_EVEN(1'b0)) u_sel_ra_op (
        .src_addr (ra_address_op), .rf_value (ra_value_op),
        .ep_values(ep_values), .ep_addrs(ep_addrs), .ep_ready(ep_ready),
        .op_values(op_values), .op_addrs(op_addrs), .op_ready(op_ready),
        .fw_value (ra_fw_op)
    );

    fw_operand_select #(.OWN_PIPE_EVEN(1'b0)) u_sel_rb_op (
        .src_addr (rb_address_op), .rf_value (rb_value_op),
        .ep_values(ep_values), .ep_addrs(ep_addrs), .ep_ready(ep_ready),
        .op_values(op_values), .op_addrs(op_addrs), .op_ready(op_ready),
        .fw_value (rb_fw_op)
    );

    fw_operand_latch u_operand_latch (
        .clock          (clock),
        .rst_n          (rst_n),
        .ra_fw_ep       (ra_fw_ep),
        .rb_fw_ep       (rb_fw_ep),
        .rc_fw_ep       (rc_fw_ep),
        .ra_fw_op       (ra_fw_op),
        .rb_fw_op       (rb_fw_op),
        .ra_value_fw_ep (ra_value_fw_ep),
        .rb_value_fw_ep (rb_value_fw_ep),
        .rc_value_fw_ep (rc_value_fw_ep),
        .ra_value_fw_op (ra_value_fw_op),
        .rb_value_fw_op (rb_value_fw_op)
    );

endmodule

// ==== rtl/fw_operand_latch.sv ====
`timescale 1ns/100ps

module fw_operand_latch import fw_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  reg_value_t ra_fw_ep,
    input  reg_value_t rb_fw_ep,
    input  reg_value_t rc_fw_ep,
    input  reg_value_t ra_fw_op,
    input  reg_value_t rb_fw_op,
    output reg_value_t ra_value_fw_ep,
    output reg_value_t rb_value_fw_ep,
    output reg_value_t rc_value_fw_ep,
    output reg_value_t ra_value_fw_op,
    output reg_value_t rb_value_fw_op
);

    // operand registers of the next stage, a new set lands every cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ra_value_fw_ep <= '0;
            rb_value_fw_ep <= '0;
            rc_value_fw_ep <= '0;
            ra_value_fw_op <= '0;
            rb_value_fw_op <= '0;
        end else begin
            ra_value_fw_ep <= ra_fw_ep;
            rb_value_fw_ep <= rb_fw_ep;
            rc_value_fw_ep <= rc_fw_ep;
            ra_value_fw_op <= ra_fw_op;
            rb_value_fw_op <= rb_fw_op;
        end
    end

    // the next stage must never see a stale operand coming out of reset
    a_reset_clears: assert property (
        @(posedge clock)
        !rst_n |=> (ra_value_fw_ep == '0) && (rb_value_fw_ep == '0)
                   && (rc_value_fw_ep == '0) && (ra_value_fw_op == '0)
                   && (rb_value_fw_op == '0)
    ) else $error("operand registers not cleared after reset");

endmodule

// ==== rtl/fw_operand_select.sv ====
`timescale 1ns/100ps

`include "fw_defines.svh"

module fw_operand_select import fw_pkg::*; #(
    parameter bit OWN_PIPE_EVEN = 1'b1  // 1 for even-pipe consumers, 0 for odd
) (
    input  reg_addr_t     src_addr,
    input  reg_value_t    rf_value,
    input  stage_values_t ep_values,
    input  stage_addrs_t  ep_addrs,
    input  stage_ready_t  ep_ready,
    input  stage_values_t op_values,
    input  stage_addrs_t  op_addrs,
    input  stage_ready_t  op_ready,
    output reg_value_t    fw_value
);

    stage_values_t own_values;
    stage_values_t other_values;
    stage_addrs_t  own_addrs;
    stage_addrs_t  other_addrs;
    stage_ready_t  own_ready;
    stage_ready_t  other_ready;
    stage_ready_t  own_match;
    stage_ready_t  other_match;
    logic          found;

    // fold the two pipes into own and other so one search serves both kinds of consumer
    assign own_values   = OWN_PIPE_EVEN ? ep_values : op_values;
    assign own_addrs    = OWN_PIPE_EVEN ? ep_addrs  : op_addrs;
    assign own_ready    = OWN_PIPE_EVEN ? ep_ready  : op_ready;
    assign other_values = OWN_PIPE_EVEN ? op_values : ep_values;
    assign other_addrs  = OWN_PIPE_EVEN ? op_addrs  : ep_addrs;
    assign other_ready  = OWN_PIPE_EVEN ? op_ready  : ep_ready;

    for (genvar d = 1; d <= `FW_NUM_STAGES; d++) begin : g_match
        assign own_match[d]   = own_ready[d] && (own_addrs[d] == src_addr);
        assign other_match[d] = other_ready[d] && (other_addrs[d] == src_addr);
    end

    // youngest first, and the own pipe breaks a tie at equal depth
    always_comb begin
        fw_value = rf_value;  // nothing in flight means the register file is current
        found    = 1'b0;
        for (int d = 1; d <= `FW_NUM_STAGES; d++) begin
            if (!found && own_match[d]) begin
                fw_value = own_values[d];
                found    = 1'b1;
            end
            if (!found && other_match[d]) begin
                fw_value = other_values[d];
                found    = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/fw_stage_table.sv ====
`timescale 1ns/100ps

`include "fw_defines.svh"

module fw_stage_table import fw_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  stage_records_t ep_stage_records,
    input  stage_records_t op_stage_records,
    output stage_values_t  ep_values,
    output stage_addrs_t   ep_addrs,
    output stage_ready_t   ep_ready,
    output stage_values_t  op_values,
    output stage_addrs_t   op_addrs,
    output stage_ready_t   op_ready
);

    logic [1:`FW_NUM_STAGES] ep_we;
    logic [1:`FW_NUM_STAGES] op_we;
    unit_latency_t           ep_lat [1:`FW_NUM_STAGES];
    unit_latency_t           op_lat [1:`FW_NUM_STAGES];

    for (genvar d = 1; d <= `FW_NUM_STAGES; d++) begin : g_stage
        // the unit id bits ride along in the record but nothing here looks at them
        assign ep_values[d] = ep_stage_records[d][`FW_VALUE_MSB:`FW_VALUE_LSB];
        assign ep_we[d]     = ep_stage_records[d][`FW_WE_BIT];
        assign ep_addrs[d]  = ep_stage_records[d][`FW_ADDR_MSB:`FW_ADDR_LSB];
        assign ep_lat[d]    = ep_stage_records[d][`FW_LAT_MSB:`FW_LAT_LSB];

        assign op_values[d] = op_stage_records[d][`FW_VALUE_MSB:`FW_VALUE_LSB];
        assign op_we[d]     = op_stage_records[d][`FW_WE_BIT];
        assign op_addrs[d]  = op_stage_records[d][`FW_ADDR_MSB:`FW_ADDR_LSB];
        assign op_lat[d]    = op_stage_records[d][`FW_LAT_MSB:`FW_LAT_LSB];

        // a result exists once the unit has run for its full latency
        assign ep_ready[d] = ep_we[d] && (ep_lat[d] != '0)
                             && (ep_lat[d] <= unit_latency_t'(d));
        assign op_ready[d] = op_we[d] && (op_lat[d] != '0)
                             && (op_lat[d] <= unit_latency_t'(d));

        // a live record must come from a unit that can finish by write-back
        a_ep_lat_range: assert property (
            @(posedge clock) disable iff (!rst_n)
            ep_we[d] |-> (ep_lat[d] != '0)
                         && (ep_lat[d] <= unit_latency_t'(`FW_NUM_STAGES))
        ) else $error("even stage %0d carries latency %0d", d, ep_lat[d]);

        a_op_lat_range: assert property (
            @(posedge clock) disable iff (!rst_n)
            op_we[d] |-> (op_lat[d] != '0)
                         && (op_lat[d] <= unit_latency_t'(`FW_NUM_STAGES))
        ) else $error("odd stage %0d carries latency %0d", d, op_lat[d]);
    end

endmodule

// ==== rtl/fw_pkg.sv ====
`include "fw_defines.svh"

package fw_pkg;

    typedef logic [0:`FW_ADDR_W-1]   reg_addr_t;
    typedef logic [0:`FW_VALUE_W-1]  reg_value_t;
    typedef logic [0:`FW_LAT_W-1]    unit_latency_t;
    typedef logic [0:`FW_RECORD_W-1] stage_record_t;

    // index is the stage depth, 1 is the youngest and 8 is write-back
    typedef stage_record_t [1:`FW_NUM_STAGES] stage_records_t;
    typedef reg_value_t    [1:`FW_NUM_STAGES] stage_values_t;
    typedef reg_addr_t     [1:`FW_NUM_STAGES] stage_addrs_t;
    typedef logic          [1:`FW_NUM_STAGES] stage_ready_t;

endpackage

// ==== rtl/fw_defines.svh ====
`ifndef FW_DEFINES_SVH
`define FW_DEFINES_SVH

`define FW_VALUE_W      128
`define FW_ADDR_W       7
`define FW_UNIT_ID_W    3
`define FW_LAT_W        4
`define FW_NUM_STAGES   8  // seven execution stages plus write-back

`define FW_RECORD_W     (`FW_UNIT_ID_W + `FW_VALUE_W + 1 + `FW_ADDR_W + `FW_LAT_W)

// record fields use big-endian numbering, bit 0 is the first bit on the bus
`define FW_ID_MSB       0
`define FW_ID_LSB       (`FW_ID_MSB + `FW_UNIT_ID_W - 1)
`define FW_VALUE_MSB    (`FW_ID_LSB + 1)
`define FW_VALUE_LSB    (`FW_VALUE_MSB + `FW_VALUE_W - 1)
`define FW_WE_BIT       (`FW_VALUE_LSB + 1)
`define FW_ADDR_MSB     (`FW_WE_BIT + 1)
`define FW_ADDR_LSB     (`FW_ADDR_MSB + `FW_ADDR_W - 1)
`define FW_LAT_MSB      (`FW_ADDR_LSB + 1)
`define FW_LAT_LSB      (`FW_LAT_MSB + `FW_LAT_W - 1)

`endif
